// File: project.f
rtl/core_pkg.sv
rtl/core_alu.sv
rtl/core_regfile.sv
rtl/core_controller.sv
rtl/core_datapath.sv
rtl/core_top.sv
test/tb_core_mem.sv
test/tb_core.sv

// File: rtl/core_alu.sv
// Arithmetic and logic unit with the branch condition comparator
`timescale 1ns/1ps

module core_alu (
  input  logic [core_pkg::XLEN-1:0] operand_a_i,
  input  logic [core_pkg::XLEN-1:0] operand_b_i,
  input  core_pkg::alu_op_e         alu_op_i,
  input  logic [core_pkg::XLEN-1:0] cmp_a_i,
  input  logic [core_pkg::XLEN-1:0] cmp_b_i,
  input  core_pkg::branch_op_e      branch_op_i,
  output logic [core_pkg::XLEN-1:0] result_o,
  output logic                      branch_taken_o
);

  logic [4:0] shamt;
  logic       lt_signed;
  logic       lt_unsigned;

  assign shamt       = operand_b_i[4:0];
  assign lt_signed   = $signed(operand_a_i) < $signed(operand_b_i);
  assign lt_unsigned = operand_a_i < operand_b_i;

  always_comb
  begin
    case (alu_op_i)
      core_pkg::OP_ALU_ADD:  result_o = operand_a_i + operand_b_i;
      core_pkg::OP_ALU_SUB:  result_o = operand_a_i - operand_b_i;
      core_pkg::OP_ALU_SLL:  result_o = operand_a_i << shamt;
      core_pkg::OP_ALU_SLT:  result_o = {{(core_pkg::XLEN-1){1'b0}}, lt_signed};
      core_pkg::OP_ALU_SLTU: result_o = {{(core_pkg::XLEN-1){1'b0}}, lt_unsigned};
      core_pkg::OP_ALU_XOR:  result_o = operand_a_i ^ operand_b_i;
      core_pkg::OP_ALU_SRL:  result_o = operand_a_i >> shamt;
      core_pkg::OP_ALU_SRA:  result_o = $unsigned($signed(operand_a_i) >>> shamt);
      core_pkg::OP_ALU_OR:   result_o = operand_a_i | operand_b_i;
      core_pkg::OP_ALU_AND:  result_o = operand_a_i & operand_b_i;
      default:               result_o = '0;   // NOP
    endcase
  end

  // -------------------------------------------------------------------------
  // Branch conditions on the register operands
  // -------------------------------------------------------------------------
  always_comb
  begin
    case (branch_op_i)
      core_pkg::BRANCH_BEQ:      branch_taken_o = (cmp_a_i == cmp_b_i);
      core_pkg::BRANCH_BNE:      branch_taken_o = (cmp_a_i != cmp_b_i);
      core_pkg::BRANCH_BLT:      branch_taken_o = $signed(cmp_a_i) < $signed(cmp_b_i);
      core_pkg::BRANCH_BGE:      branch_taken_o = $signed(cmp_a_i) >= $signed(cmp_b_i);
      core_pkg::BRANCH_BLTU:     branch_taken_o = cmp_a_i < cmp_b_i;
      core_pkg::BRANCH_BGEU:     branch_taken_o = cmp_a_i >= cmp_b_i;
      core_pkg::BRANCH_JAL_JALR: branch_taken_o = 1'b1;   // Unconditional
      default:                   branch_taken_o = 1'b0;
    endcase
  end

endmodule

// File: rtl/core_controller.sv
// Fetch and execute state machine with instruction decode into the control struct
`timescale 1ns/1ps

module core_controller (
  input  logic            clk_i,
  input  logic            rstn_i,
  input  core_pkg::inst_u inst_i,
  output core_pkg::inst_u inst_o,
  output core_pkg::ctrl_t ctrl_o
);

  typedef enum logic [1:0] {
    ST_FETCH,
    ST_EXE_1,
    ST_EXE_2
  } state_e;

  state_e               state_q;
  state_e               state_d;
  core_pkg::inst_u      inst_q;
  logic [6:0]           opcode;
  logic [2:0]           funct3;
  logic                 alt_op;
  logic                 two_exe;
  core_pkg::alu_op_e    r_alu_op;
  core_pkg::alu_op_e    i_alu_op;
  core_pkg::branch_op_e br_op;

  assign opcode  = inst_q.r_fmt.opcode;
  assign funct3  = inst_q.r_fmt.funct3;
  assign alt_op  = inst_q.r_fmt.funct7[5];   // SUB and SRA select
  assign two_exe = (opcode == core_pkg::OP_LOAD) || (opcode == core_pkg::OP_JAL) ||
                   (opcode == core_pkg::OP_JALR);
  assign inst_o  = inst_q;

  // -------------------------------------------------------------------------
  // State register and instruction latch
  // -------------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rstn_i)
  begin
    if (!rstn_i)
      state_q <= ST_FETCH;
    else
      state_q <= state_d;
  end

  always_comb
  begin
    case (state_q)
      ST_FETCH: state_d = ST_EXE_1;
      ST_EXE_1: state_d = two_exe ? ST_EXE_2 : ST_FETCH;   // Loads and jumps need EXE_2
      default:  state_d = ST_FETCH;
    endcase
  end

  always_ff @(posedge clk_i)
  begin
    if (state_q == ST_FETCH)
      inst_q <= inst_i;
  end

  // -------------------------------------------------------------------------
  // Field decode
  // -------------------------------------------------------------------------
  always_comb
  begin
    case ({alt_op, funct3})
      4'b0000: r_alu_op = core_pkg::OP_ALU_ADD;
      4'b1000: r_alu_op = core_pkg::OP_ALU_SUB;
      4'b0001: r_alu_op = core_pkg::OP_ALU_SLL;
      4'b0010: r_alu_op = core_pkg::OP_ALU_SLT;
      4'b0011: r_alu_op = core_pkg::OP_ALU_SLTU;
      4'b0100: r_alu_op = core_pkg::OP_ALU_XOR;
      4'b0101: r_alu_op = core_pkg::OP_ALU_SRL;
      4'b1101: r_alu_op = core_pkg::OP_ALU_SRA;
      4'b0110: r_alu_op = core_pkg::OP_ALU_OR;
      4'b0111: r_alu_op = core_pkg::OP_ALU_AND;
      default: r_alu_op = core_pkg::OP_ALU_NOP;
    endcase
  end

  // Immediate forms ignore funct7 except on shifts
  always_comb
  begin
    case (funct3)
      3'b000:  i_alu_op = core_pkg::OP_ALU_ADD;
      3'b001:  i_alu_op = core_pkg::OP_ALU_SLL;
      3'b010:  i_alu_op = core_pkg::OP_ALU_SLT;
      3'b011:  i_alu_op = core_pkg::OP_ALU_SLTU;
      3'b100:  i_alu_op = core_pkg::OP_ALU_XOR;
      3'b101:  i_alu_op = alt_op ? core_pkg::OP_ALU_SRA : core_pkg::OP_ALU_SRL;
      3'b110:  i_alu_op = core_pkg::OP_ALU_OR;
      default: i_alu_op = core_pkg::OP_ALU_AND;
    endcase
  end

  always_comb
  begin
    case (funct3)
      3'b001:  br_op = core_pkg::BRANCH_BNE;
      3'b100:  br_op = core_pkg::BRANCH_BLT;
      3'b101:  br_op = core_pkg::BRANCH_BGE;
      3'b110:  br_op = core_pkg::BRANCH_BLTU;
      3'b111:  br_op = core_pkg::BRANCH_BGEU;
      default: br_op = core_pkg::BRANCH_BEQ;
    endcase
  end

  // -------------------------------------------------------------------------
  // Control outputs per state
  // -------------------------------------------------------------------------
  always_comb
  begin
    ctrl_o            = '0;
    ctrl_o.branch_op  = core_pkg::BRANCH_BEQ;
    ctrl_o.result_sel = core_pkg::RES_ALU;
    ctrl_o.alu_op     = core_pkg::OP_ALU_ADD;
    ctrl_o.rs1_addr   = inst_q.r_fmt.rs1;
    ctrl_o.rs2_addr   = inst_q.r_fmt.rs2;
    ctrl_o.rd_addr    = inst_q.r_fmt.rd;
    case (state_q)
      ST_EXE_1:
      begin
        ctrl_o.pc_en = !two_exe;   // Loads and jumps step the PC in EXE_2
        case (opcode)
          core_pkg::OP_ALU:
          begin
            ctrl_o.alu_op    = r_alu_op;
            ctrl_o.reg_write = 1'b1;
          end
          core_pkg::OP_ALUI:
          begin
            ctrl_o.alu_op    = i_alu_op;
            ctrl_o.alu_src_b = 1'b1;
            ctrl_o.reg_write = 1'b1;
          end
          core_pkg::OP_LUI:
          begin
            ctrl_o.rs1_addr  = '0;     // x0 + upper immediate
            ctrl_o.alu_src_b = 1'b1;
            ctrl_o.reg_write = 1'b1;
          end
          core_pkg::OP_AUIPC:
          begin
            ctrl_o.alu_src_a = 1'b1;
            ctrl_o.alu_src_b = 1'b1;
            ctrl_o.reg_write = 1'b1;
          end
          core_pkg::OP_LOAD:
          begin
            ctrl_o.alu_src_b = 1'b1;
            ctrl_o.mem_read  = 1'b1;   // Data arrives in EXE_2
          end
          core_pkg::OP_STORE:
          begin
            ctrl_o.alu_src_b = 1'b1;
            ctrl_o.mem_write = 1'b1;
          end
          core_pkg::OP_BRANCH:
          begin
            ctrl_o.alu_src_a = 1'b1;   // Target is PC + offset
            ctrl_o.alu_src_b = 1'b1;
            ctrl_o.branch    = 1'b1;
            ctrl_o.branch_op = br_op;
          end
          core_pkg::OP_FENCE, core_pkg::OP_SYSTEM: ctrl_o.alu_op = core_pkg::OP_ALU_NOP;
          default: ;
        endcase
      end
      ST_EXE_2:
      begin
        ctrl_o.pc_en     = 1'b1;
        ctrl_o.alu_src_b = 1'b1;
        ctrl_o.reg_write = 1'b1;
        if (opcode == core_pkg::OP_LOAD)
          ctrl_o.result_sel = core_pkg::RES_MEM;
        else
        begin
          ctrl_o.result_sel = core_pkg::RES_PC4;   // Link value
          ctrl_o.alu_src_a  = (opcode == core_pkg::OP_JAL);
          ctrl_o.branch     = 1'b1;
          ctrl_o.branch_op  = core_pkg::BRANCH_JAL_JALR;
        end
      end
      default: ;
    endcase
  end

  assert property (@(posedge clk_i) disable iff (!rstn_i)
    state_q inside {ST_FETCH, ST_EXE_1, ST_EXE_2})
    else $error("Controller state left its legal range");

  assert property (@(posedge clk_i) disable iff (!rstn_i)
    !(ctrl_o.mem_write && ctrl_o.reg_write))
    else $error("Store and register write in the same cycle");

endmodule

// File: rtl/core_datapath.sv
// Program counter, immediate generation, operand and writeback muxes, next PC
`timescale 1ns/1ps

module core_datapath (
  input  logic                      clk_i,
  input  logic                      rstn_i,
  input  core_pkg::inst_u           inst_i,
  input  core_pkg::ctrl_t           ctrl_i,
  input  logic [core_pkg::XLEN-1:0] rs1_data_i,
  input  logic [core_pkg::XLEN-1:0] rs2_data_i,
  input  logic [core_pkg::XLEN-1:0] alu_result_i,
  input  logic                      branch_taken_i,
  input  logic [core_pkg::XLEN-1:0] dmem_rdata_i,
  output logic [core_pkg::XLEN-1:0] pc_o,
  output logic [core_pkg::XLEN-1:0] alu_a_o,
  output logic [core_pkg::XLEN-1:0] alu_b_o,
  output logic [core_pkg::XLEN-1:0] rd_wdata_o,
  output core_pkg::dmem_req_t       dmem_req_o
);

  logic [core_pkg::XLEN-1:0] pc_q;
  logic [core_pkg::XLEN-1:0] pc_plus4;
  logic [core_pkg::XLEN-1:0] imm;
  logic [core_pkg::XLEN-1:0] target;
  logic [6:0]                opcode;

  assign opcode   = inst_i.r_fmt.opcode;
  assign pc_plus4 = pc_q + 32'd4;
  assign pc_o     = pc_q;

  // -------------------------------------------------------------------------
  // Immediate by format
  // -------------------------------------------------------------------------
  always_comb
  begin
    case (opcode)
      core_pkg::OP_STORE:
        imm = {{20{inst_i.s_fmt.imm_11_5[6]}}, inst_i.s_fmt.imm_11_5, inst_i.s_fmt.imm_4_0};
      core_pkg::OP_BRANCH:
        imm = {{19{inst_i.b_fmt.imm_12}}, inst_i.b_fmt.imm_12, inst_i.b_fmt.imm_11,
               inst_i.b_fmt.imm_10_5, inst_i.b_fmt.imm_4_1, 1'b0};
      core_pkg::OP_LUI, core_pkg::OP_AUIPC:
        imm = {inst_i.u_fmt.imm_31_12, 12'b0};
      core_pkg::OP_JAL:
        imm = {{11{inst_i.j_fmt.imm_20}}, inst_i.j_fmt.imm_20, inst_i.j_fmt.imm_19_12,
               inst_i.j_fmt.imm_11, inst_i.j_fmt.imm_10_1, 1'b0};
      default:
        imm = {{20{inst_i.i_fmt.imm_11_0[11]}}, inst_i.i_fmt.imm_11_0};   // I-type
    endcase
  end

  // -------------------------------------------------------------------------
  // Operand, writeback and memory request
  // -------------------------------------------------------------------------
  assign alu_a_o = ctrl_i.alu_src_a ? pc_q : rs1_data_i;
  assign alu_b_o = ctrl_i.alu_src_b ? imm  : rs2_data_i;

  always_comb
  begin
    case (ctrl_i.result_sel)
      core_pkg::RES_PC4: rd_wdata_o = pc_plus4;
      core_pkg::RES_MEM: rd_wdata_o = dmem_rdata_i;
      default:           rd_wdata_o = alu_result_i;
    endcase
  end

  assign dmem_req_o.addr  = alu_result_i;
  assign dmem_req_o.wdata = rs2_data_i;
  assign dmem_req_o.we    = ctrl_i.mem_write;
  assign dmem_req_o.re    = ctrl_i.mem_read;

  // -------------------------------------------------------------------------
  // Next PC
  // -------------------------------------------------------------------------
  always_comb
  begin
    target = alu_result_i;
    if (opcode == core_pkg::OP_JALR)
      target[0] = 1'b0;
  end

  always_ff @(posedge clk_i or negedge rstn_i)
  begin
    if (!rstn_i)
      pc_q <= '0;
    else if (ctrl_i.pc_en)
    begin
      if (ctrl_i.branch && branch_taken_i)
        pc_q <= target;
      else
        pc_q <= pc_plus4;
    end
  end

  assert property (@(posedge clk_i) disable iff (!rstn_i)
    ctrl_i.pc_en |=> (pc_q[1:0] == 2'b00))
    else $error("PC update left a misaligned address");

endmodule

// File: rtl/core_pkg.sv
// Core widths, opcodes, ALU and branch codes, instruction formats and control structs
package core_pkg;

  localparam int XLEN     = 32;
  localparam int NUM_REGS = 32;

  // -------------------------------------------------------------------------
  // Major opcodes
  // -------------------------------------------------------------------------
  localparam logic [6:0] OP_ALU    = 7'b0110011;
  localparam logic [6:0] OP_ALUI   = 7'b0010011;
  localparam logic [6:0] OP_LOAD   = 7'b0000011;
  localparam logic [6:0] OP_STORE  = 7'b0100011;
  localparam logic [6:0] OP_BRANCH = 7'b1100011;
  localparam logic [6:0] OP_JAL    = 7'b1101111;
  localparam logic [6:0] OP_JALR   = 7'b1100111;
  localparam logic [6:0] OP_LUI    = 7'b0110111;
  localparam logic [6:0] OP_AUIPC  = 7'b0010111;
  localparam logic [6:0] OP_FENCE  = 7'b0001111;
  localparam logic [6:0] OP_SYSTEM = 7'b1110011;

  typedef enum logic [5:0] {
    OP_ALU_ADD,
    OP_ALU_SUB,
    OP_ALU_SLL,
    OP_ALU_SLT,
    OP_ALU_SLTU,
    OP_ALU_XOR,
    OP_ALU_SRL,
    OP_ALU_SRA,
    OP_ALU_OR,
    OP_ALU_AND,
    OP_ALU_NOP
  } alu_op_e;

  typedef enum logic [2:0] {
    BRANCH_BEQ,
    BRANCH_BNE,
    BRANCH_BLT,
    BRANCH_BGE,
    BRANCH_BLTU,
    BRANCH_BGEU,
    BRANCH_JAL_JALR
  } branch_op_e;

  typedef enum logic [1:0] {
    RES_ALU,
    RES_PC4,
    RES_MEM
  } result_sel_e;

  // -------------------------------------------------------------------------
  // Instruction formats with the MSB first
  // -------------------------------------------------------------------------
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm_11_0;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0] imm_11_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_4_0;
    logic [6:0] opcode;
  } s_fmt_t;

  typedef struct packed {
    logic       imm_12;
    logic [5:0] imm_10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm_4_1;
    logic       imm_11;
    logic [6:0] opcode;
  } b_fmt_t;

  typedef struct packed {
    logic [19:0] imm_31_12;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } u_fmt_t;

  typedef struct packed {
    logic       imm_20;
    logic [9:0] imm_10_1;
    logic       imm_11;
    logic [7:0] imm_19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } j_fmt_t;

  typedef union packed {
    r_fmt_t r_fmt;
    i_fmt_t i_fmt;
    s_fmt_t s_fmt;
    b_fmt_t b_fmt;
    u_fmt_t u_fmt;
    j_fmt_t j_fmt;
  } inst_u;

  typedef struct packed {
    logic        pc_en;
    logic        branch;
    branch_op_e  branch_op;
    result_sel_e result_sel;
    logic        mem_write;
    logic        mem_read;
    logic        alu_src_a;   // 0 rs1, 1 PC
    logic        alu_src_b;   // 0 rs2, 1 immediate
    logic        reg_write;
    alu_op_e     alu_op;
    logic [4:0]  rs1_addr;
    logic [4:0]  rs2_addr;
    logic [4:0]  rd_addr;
  } ctrl_t;

  typedef struct packed {
    logic [XLEN-1:0] addr;
    logic [XLEN-1:0] wdata;
    logic            we;
    logic            re;
  } dmem_req_t;

endpackage

// File: rtl/core_regfile.sv
// Register file with two asynchronous read ports, one write port and x0 tied to zero
`timescale 1ns/1ps

module core_regfile (
  input  logic                      clk_i,
  input  logic                      rstn_i,
  input  logic [4:0]                rs1_addr_i,
  input  logic [4:0]                rs2_addr_i,
  input  logic [4:0]                rd_addr_i,
  input  logic                      we_i,
  input  logic [core_pkg::XLEN-1:0] wdata_i,
  output logic [core_pkg::XLEN-1:0] rs1_data_o,
  output logic [core_pkg::XLEN-1:0] rs2_data_o
);

  logic [core_pkg::XLEN-1:0] regs [core_pkg::NUM_REGS];

  always_ff @(posedge clk_i or negedge rstn_i)
  begin
    if (!rstn_i)
    begin
      for (int i = 0; i < core_pkg::NUM_REGS; i++)
        regs[i] <= '0;
    end
    else if (we_i && (rd_addr_i != '0))   // Entry 0 is never written
      regs[rd_addr_i] <= wdata_i;
  end

  assign rs1_data_o = regs[rs1_addr_i];
  assign rs2_data_o = regs[rs2_addr_i];

  assert property (@(posedge clk_i) disable iff (!rstn_i)
    (rs1_addr_i == '0) |-> (rs1_data_o == '0))
    else $error("x0 read back a nonzero value");

endmodule

// File: rtl/core_top.sv
// Core top level wiring controller, datapath, ALU and register file to the memory ports
`timescale 1ns/1ps

module core_top (
  input  logic                      clk_i,
  input  logic                      rstn_i,
  output logic [core_pkg::XLEN-1:0] imem_addr_o,
  input  core_pkg::inst_u           imem_data_i,
  output core_pkg::dmem_req_t       dmem_req_o,
  input  logic [core_pkg::XLEN-1:0] dmem_rdata_i
);

  core_pkg::inst_u           inst;
  core_pkg::ctrl_t           ctrl;
  logic [core_pkg::XLEN-1:0] rs1_data;
  logic [core_pkg::XLEN-1:0] rs2_data;
  logic [core_pkg::XLEN-1:0] alu_a;
  logic [core_pkg::XLEN-1:0] alu_b;
  logic [core_pkg::XLEN-1:0] alu_result;
  logic [core_pkg::XLEN-1:0] rd_wdata;
  logic                      branch_taken;

  core_controller controller_i (
    .clk_i  (clk_i),
    .rstn_i (rstn_i),
    .inst_i (imem_data_i),
    .inst_o (inst),
    .ctrl_o (ctrl)
  );

  core_datapath datapath_i (
    .clk_i          (clk_i),
    .rstn_i         (rstn_i),
    .inst_i         (inst),
    .ctrl_i         (ctrl),
    .rs1_data_i     (rs1_data),
    .rs2_data_i     (rs2_data),
    .alu_result_i   (alu_result),
    .branch_taken_i (branch_taken),
    .dmem_rdata_i   (dmem_rdata_i),
    .pc_o           (imem_addr_o),   // PC addresses instruction memory
    .alu_a_o        (alu_a),
    .alu_b_o        (alu_b),
    .rd_wdata_o     (rd_wdata),
    .dmem_req_o     (dmem_req_o)
  );

  core_alu alu_i (
    .operand_a_i    (alu_a),
    .operand_b_i    (alu_b),
    .alu_op_i       (ctrl.alu_op),
    .cmp_a_i        (rs1_data),
    .cmp_b_i        (rs2_data),
    .branch_op_i    (ctrl.branch_op),
    .result_o       (alu_result),
    .branch_taken_o (branch_taken)
  );

  core_regfile regfile_i (
    .clk_i      (clk_i),
    .rstn_i     (rstn_i),
    .rs1_addr_i (ctrl.rs1_addr),
    .rs2_addr_i (ctrl.rs2_addr),
    .rd_addr_i  (ctrl.rd_addr),
    .we_i       (ctrl.reg_write),
    .wdata_i    (rd_wdata),
    .rs1_data_o (rs1_data),
    .rs2_data_o (rs2_data)
  );

endmodule

// File: run.sh
#!/usr/bin/env bash
# Build the core testbench with Verilator, run it and decide pass or fail from the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tb_core -f project.f -o tb_core \
  || { echo "Verilator build failed"; exit 1; }
./obj_dir/tb_core 2>&1 | tee sim.log
grep -qx "Simulation PASSED" sim.log && exit 0 || exit 1

// File: test/tb_core.sv
// Core testbench with clock, reset, generated program, store checks, timeout and summary
`timescale 1ns/1ps

module tb_core;

  logic                clk;
  logic                rstn;
  logic [31:0]         imem_addr;
  core_pkg::inst_u     imem_data;
  core_pkg::dmem_req_t dmem_req;
  logic [31:0]         dmem_rdata;

  logic [31:0] expected [256];   // Slot n sits at address 4n
  string       names    [256];
  bit          skipped  [256];
  bit          written  [256];
  int          nslots;
  int          nloads;
  int          errors;
  int          stores;
  int          reads;
  logic [31:0] pc;
  logic [31:0] end_pc;

  core_top core_top_i (
    .clk_i        (clk),
    .rstn_i       (rstn),
    .imem_addr_o  (imem_addr),
    .imem_data_i  (imem_data),
    .dmem_req_o   (dmem_req),
    .dmem_rdata_i (dmem_rdata)
  );

  tb_core_mem mem_i (
    .clk_i        (clk),
    .imem_addr_i  (imem_addr),
    .imem_data_o  (imem_data),
    .dmem_req_i   (dmem_req),
    .dmem_rdata_o (dmem_rdata)
  );

  initial
  begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // -------------------------------------------------------------------------
  // Instruction encoding
  // -------------------------------------------------------------------------
  function automatic logic [31:0] r_type(input logic [2:0] f3, input logic alt,
                                         input logic [4:0] rd, input logic [4:0] rs1,
                                         input logic [4:0] rs2);
    return {1'b0, alt, 5'b0, rs2, rs1, f3, rd, core_pkg::OP_ALU};
  endfunction

  function automatic logic [31:0] i_type(input logic [6:0] op, input logic [2:0] f3,
                                         input logic [4:0] rd, input logic [4:0] rs1,
                                         input logic [11:0] imm);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] s_type(input logic [4:0] rs1, input logic [4:0] rs2,
                                         input logic [11:0] imm);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], core_pkg::OP_STORE};
  endfunction

  function automatic logic [31:0] b_type(input logic [2:0] f3, input logic [4:0] rs1,
                                         input logic [4:0] rs2, input logic [12:0] off);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], core_pkg::OP_BRANCH};
  endfunction

  function automatic logic [31:0] u_type(input logic [6:0] op, input logic [4:0] rd,
                                         input logic [19:0] imm);
    return {imm, rd, op};
  endfunction

  function automatic logic [31:0] j_type(input logic [4:0] rd, input logic [20:0] off);
    return {off[20], off[10:1], off[11], off[19:12], rd, core_pkg::OP_JAL};
  endfunction

  // -------------------------------------------------------------------------
  // RV32I reference results
  // -------------------------------------------------------------------------
  function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                          input logic [31:0] a, input logic [31:0] b);
    case (f3)
      3'b000:  return alt ? a - b : a + b;
      3'b001:  return a << b[4:0];
      3'b010:  return {31'b0, $signed(a) < $signed(b)};
      3'b011:  return {31'b0, a < b};
      3'b100:  return a ^ b;
      3'b101:  return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'b110:  return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic bit branch_ref(input logic [2:0] f3, input logic [31:0] x,
                                    input logic [31:0] y);
    case (f3)
      3'b000:  return x == y;
      3'b001:  return x != y;
      3'b100:  return $signed(x) < $signed(y);
      3'b101:  return $signed(x) >= $signed(y);
      3'b110:  return x < y;
      default: return x >= y;
    endcase
  endfunction

  // -------------------------------------------------------------------------
  // Program building
  // -------------------------------------------------------------------------
  task automatic emit(input logic [31:0] word);
    mem_i.put_word(pc[9:2], word);
    pc = pc + 32'd4;
  endtask

  task automatic load_const(input logic [4:0] rd, input logic [31:0] value);
    emit(u_type(core_pkg::OP_LUI, rd, value[31:12] + {19'b0, value[11]}));
    emit(i_type(core_pkg::OP_ALUI, 3'b000, rd, rd, value[11:0]));   // Low part is sign-extended
  endtask

  task automatic store_slot(input string name, input logic [4:0] rs, input logic [31:0] value,
                            input bit skip);
    logic [11:0] offset;
    offset = 12'(nslots * 4);
    names[nslots] = name;
    expected[nslots] = value;
    skipped[nslots] = skip;
    nslots++;
    emit(s_type(5'd0, rs, offset));
  endtask

  task automatic build_program();
    string       r_names [10] = '{"ADD", "SUB", "SLL", "SLT", "SLTU", "XOR", "SRL", "SRA",
                                  "OR", "AND"};
    logic [3:0]  r_codes [10] = '{4'h0, 4'h8, 4'h1, 4'h2, 4'h3, 4'h4, 4'h5, 4'hd, 4'h6, 4'h7};
    string       i_names [9]  = '{"ADDI", "SLTI", "SLTIU", "XORI", "ORI", "ANDI", "SLLI",
                                  "SRLI", "SRAI"};
    logic [3:0]  i_codes [9]  = '{4'h0, 4'h2, 4'h3, 4'h4, 4'h6, 4'h7, 4'h1, 4'h5, 4'hd};
    string       b_names [6]  = '{"BEQ", "BNE", "BLT", "BGE", "BLTU", "BGEU"};
    logic [2:0]  b_f3 [6]     = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
    logic [4:0]  p_rs1 [3]    = '{5'd1, 5'd2, 5'd1};
    logic [4:0]  p_rs2 [3]    = '{5'd2, 5'd1, 5'd1};
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] at;
    logic [11:0] imm;
    logic [19:0] upper;
    bit          taken;
    string       tag;
    pc = '0;
    nslots = 0;
    nloads = 0;
    mem_i.fill_rom();
    a = $urandom();
    a[31] = 1'b1;   // Negative so signed and unsigned order differ
    b = $urandom();
    b[31] = 1'b0;
    load_const(5'd1, a);
    load_const(5'd2, b);
    for (int i = 0; i < 10; i++)
    begin
      emit(r_type(r_codes[i][2:0], r_codes[i][3], 5'd3, 5'd1, 5'd2));
      store_slot(r_names[i], 5'd3, alu_ref(r_codes[i][2:0], r_codes[i][3], a, b), 1'b0);
    end
    for (int i = 0; i < 9; i++)
    begin
      imm = 12'($urandom());
      if (i_codes[i][1:0] == 2'b01)
        imm = {1'b0, i_codes[i][3], 5'b0, imm[4:0]};   // Bit 10 of a shift picks SRAI
      emit(i_type(core_pkg::OP_ALUI, i_codes[i][2:0], 5'd3, 5'd1, imm));
      store_slot(i_names[i], 5'd3,
                 alu_ref(i_codes[i][2:0], i_codes[i][3], a, {{20{imm[11]}}, imm}), 1'b0);
    end
    upper = 20'($urandom());
    upper[7:3] = 5'd1;   // The rs1 bits point at x1 and must be ignored
    emit(u_type(core_pkg::OP_LUI, 5'd3, upper));
    store_slot("LUI", 5'd3, {upper, 12'b0}, 1'b0);
    at = pc;
    emit(u_type(core_pkg::OP_AUIPC, 5'd3, upper));
    store_slot("AUIPC", 5'd3, at + {upper, 12'b0}, 1'b0);
    emit(i_type(core_pkg::OP_LOAD, 3'b010, 5'd10, 5'd0, 12'd0));   // ADD result from slot 0
    nloads++;
    store_slot("LW round trip", 5'd10, a + b, 1'b0);
    emit(i_type(core_pkg::OP_ALUI, 3'b000, 5'd5, 5'd0, 12'h111));   // Taken marker
    emit(i_type(core_pkg::OP_ALUI, 3'b000, 5'd6, 5'd0, 12'h222));   // Not-taken marker
    for (int i = 0; i < 6; i++)
    begin
      for (int j = 0; j < 3; j++)
      begin
        taken = branch_ref(b_f3[i], (p_rs1[j] == 5'd1) ? a : b, (p_rs2[j] == 5'd1) ? a : b);
        tag = $sformatf("%s x%0d,x%0d", b_names[i], p_rs1[j], p_rs2[j]);
        emit(b_type(b_f3[i], p_rs1[j], p_rs2[j], 13'd12));
        store_slot({tag, " not taken"}, 5'd6, 32'h222, taken);
        emit(j_type(5'd0, 21'd8));
        store_slot({tag, " taken"}, 5'd5, 32'h111, !taken);
      end
    end
    at = pc;
    emit(j_type(5'd7, 21'd8));
    store_slot("JAL skipped", 5'd1, 32'd0, 1'b1);
    store_slot("JAL link", 5'd7, at + 32'd4, 1'b0);
    at = pc + 32'd8;                 // JALR follows the constant load
    load_const(5'd8, at + 32'd8);
    emit(i_type(core_pkg::OP_JALR, 3'b000, 5'd9, 5'd8, 12'd1));   // Odd sum
    store_slot("JALR skipped", 5'd1, 32'd0, 1'b1);
    store_slot("JALR link", 5'd9, at + 32'd4, 1'b0);
    emit(i_type(core_pkg::OP_ALUI, 3'b000, 5'd0, 5'd1, 12'h5a5));
    store_slot("x0 write", 5'd0, 32'd0, 1'b0);
    end_pc = pc;
    emit(j_type(5'd0, 21'd0));       // Spin here
  endtask

  // -------------------------------------------------------------------------
  // Store checks sampled at the falling edge
  // -------------------------------------------------------------------------
  function automatic bit slot_live(input logic [31:0] addr);
    return (addr[1:0] == 2'b00) && (addr < 32'(nslots * 4)) && !skipped[addr[9:2]];
  endfunction

  task automatic report_mismatch(input logic [7:0] slot, input logic [31:0] actual);
    errors++;
    $display("FAIL %s: expected %h, actual %h", names[slot], expected[slot], actual);
  endtask

  assert property (@(negedge clk) disable iff (!rstn)
    dmem_req.we |-> slot_live(dmem_req.addr))
    else
    begin
      errors++;
      $display("Store to address %h, which is a skipped or unknown slot", dmem_req.addr);
    end

  assert property (@(negedge clk) disable iff (!rstn)
    (dmem_req.we && slot_live(dmem_req.addr)) |-> (dmem_req.wdata == expected[dmem_req.addr[9:2]]))
    else report_mismatch(dmem_req.addr[9:2], dmem_req.wdata);

  assert property (@(negedge clk) disable iff (!rstn)
    imem_addr[1:0] == 2'b00)
    else
    begin
      errors++;
      $display("Instruction address %h is not word-aligned", imem_addr);
    end

  always @(negedge clk)
  begin
    if (rstn && dmem_req.we)
    begin
      written[dmem_req.addr[9:2]] = 1'b1;
      stores++;
    end
    if (rstn && dmem_req.re)
      reads++;
  end

  // -------------------------------------------------------------------------
  // Run
  // -------------------------------------------------------------------------
  initial
  begin
    int cycles;
    rstn = 1'b0;
    errors = 0;
    stores = 0;
    reads = 0;
    void'($urandom(32'h7ae1));
    for (int i = 0; i < 256; i++)
      written[i] = 1'b0;
    build_program();
    repeat (8) @(posedge clk);
    #1 rstn = 1'b1;
    cycles = 0;
    while ((imem_addr != end_pc) && (cycles < 2000))
    begin
      @(negedge clk);
      cycles++;
    end
    if (imem_addr != end_pc)
    begin
      errors++;
      $display("Timeout: the program never reached its final loop at %h", end_pc);
    end
    for (int i = 0; i < nslots; i++)
      assert (written[i] || skipped[i])
      else
      begin
        errors++;
        $display("Slot %0d (%s) was never stored", i, names[i]);
      end
    assert (reads == nloads)
    else
    begin
      errors++;
      $display("FAIL data read requests: expected %0d, actual %0d", nloads, reads);
    end
    $display("Stores seen: %0d, slots: %0d, errors: %0d", stores, nslots, errors);
    if (errors == 0)
    begin
      $display("Simulation PASSED");
    end
    else
    begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

// File: test/tb_core_mem.sv
// Testbench instruction ROM with combinational read and data RAM with one-cycle read latency
`timescale 1ns/1ps

module tb_core_mem (
  input  logic                clk_i,
  input  logic [31:0]         imem_addr_i,
  output core_pkg::inst_u     imem_data_o,
  input  core_pkg::dmem_req_t dmem_req_i,
  output logic [31:0]         dmem_rdata_o
);

  logic [31:0] rom [256];
  logic [31:0] ram [256];
  logic [31:0] rdata_q = '0;

  // -------------------------------------------------------------------------
  // Instruction ROM
  // -------------------------------------------------------------------------
  assign imem_data_o = rom[imem_addr_i[9:2]];

  // ADDI x0, x0, index so a stray fetch is a harmless no-op
  task automatic fill_rom();
    for (int i = 0; i < 256; i++)
      rom[i] = {4'b0000, 8'(i), 5'd0, 3'b000, 5'd0, core_pkg::OP_ALUI};
  endtask

  task automatic put_word(input logic [7:0] idx, input logic [31:0] word);
    rom[idx] = word;
  endtask

  // -------------------------------------------------------------------------
  // Data RAM
  // -------------------------------------------------------------------------
  initial
  begin
    for (int i = 0; i < 256; i++)
      ram[i] <= 32'hc0de_0000 ^ (32'(i) * 32'h0001_0001);
  end

  always @(posedge clk_i)
  begin
    if (dmem_req_i.we)
      ram[dmem_req_i.addr[9:2]] <= dmem_req_i.wdata;
    if (dmem_req_i.re)
      rdata_q <= ram[dmem_req_i.addr[9:2]];   // Seen by the core in EXE_2
  end

  assign dmem_rdata_o = rdata_q;

endmodule
